/* rtl/dspTilePkg.sv */
package dspTilePkg;

	// default widths, the top level passes its own values down
	localparam int OpWidthDef = 8;  // operands a and b
	localparam int AccWidthDef = 20;  // c, accumulator and slice result

	localparam int SliceCfgBits = 6;  // per slice
	localparam int CombCfgBits = 2;  // combiner only

	// whole serial frame, two slices plus the combiner
	localparam int FrameBits = 2 * SliceCfgBits + CombCfgBits;

	typedef logic [OpWidthDef-1:0] operandT;  // operand a or b
	typedef logic [AccWidthDef-1:0] accT;  // c, accumulator, q
	typedef logic [AccWidthDef:0] dotSumT;  // one guard bit over accT
	typedef logic [SliceCfgBits-1:0] sliceCfgT;
	typedef logic [CombCfgBits-1:0] combCfgT;

	// slice configuration bits
	localparam int CfgRegA = 0;  // registered operand a
	localparam int CfgRegB = 1;  // registered operand b
	localparam int CfgRegC = 2;  // registered operand c
	localparam int CfgAccumulate = 3;  // add to acc instead of c
	localparam int CfgSigned = 4;  // two's complement multiply
	localparam int CfgOutAcc = 5;  // q shows acc instead of sum

	// combiner configuration bits
	localparam int CombSigned = 0;  // sign extend qA and qB
	localparam int CombRegistered = 1;  // dotSum through a register

	// field positions inside the frame
	// the first bit shifted in ends up at the top, in the combiner field
	localparam int Slice0Lsb = 0;
	localparam int Slice1Lsb = Slice0Lsb + SliceCfgBits;
	localparam int CombLsb = Slice1Lsb + SliceCfgBits;

endpackage

/* rtl/configChain.sv */
module configChain (
	input  logic                  UserCLK,
	input  logic                  rst,
	input  logic                  cfgData,
	input  logic                  cfgShift,
	input  logic                  cfgLatch,
	output dspTilePkg::sliceCfgT  sliceCfg0,
	output dspTilePkg::sliceCfgT  sliceCfg1,
	output dspTilePkg::combCfgT   combCfg
);

	import dspTilePkg::*;

	logic [FrameBits-1:0] shiftReg;  // frame being loaded
	logic [FrameBits-1:0] activeFrame;  // frame in use

	// serial load, new bit enters at the bottom
	always_ff @(posedge UserCLK) begin
		if (rst) begin
			shiftReg <= '0;
		end else if (cfgShift) begin
			shiftReg <= {shiftReg[FrameBits-2:0], cfgData};
		end
	end

	// the slices keep the old frame until the latch strobe,
	// so a new frame can be loaded while the tile is working
	always_ff @(posedge UserCLK) begin
		if (rst) begin
			activeFrame <= '0;  // direct, add-c, unsigned, sum out
		end else if (cfgLatch) begin
			activeFrame <= shiftReg;  // value before any shift this edge
		end
	end

	assign sliceCfg0 = activeFrame[Slice0Lsb +: SliceCfgBits];
	assign sliceCfg1 = activeFrame[Slice1Lsb +: SliceCfgBits];
	assign combCfg = activeFrame[CombLsb +: CombCfgBits];

endmodule

/* rtl/mulAdd.sv */
module mulAdd #(
	parameter int OpWidth = dspTilePkg::OpWidthDef,
	parameter int AccWidth = dspTilePkg::AccWidthDef
) (
	input  logic                  UserCLK,
	input  logic                  rst,
	input  logic                  clr,
	input  logic [OpWidth-1:0]    a,
	input  logic [OpWidth-1:0]    b,
	input  logic [AccWidth-1:0]   c,
	input  dspTilePkg::sliceCfgT  cfg,
	output logic [AccWidth-1:0]   q
);

	import dspTilePkg::*;

	localparam int ProdWidth = 2 * OpWidth;  // full product
	localparam int ExtWidth = AccWidth - ProdWidth;  // guard bits above it

	logic [OpWidth-1:0] aReg;  // optional input registers
	logic [OpWidth-1:0] bReg;
	logic [AccWidth-1:0] cReg;

	logic [OpWidth-1:0] opA;  // selected operands
	logic [OpWidth-1:0] opB;
	logic [AccWidth-1:0] opC;

	logic [ProdWidth-1:0] opAExt;
	logic [ProdWidth-1:0] opBExt;
	logic [ProdWidth-1:0] product;
	logic [AccWidth-1:0] productExt;

	logic [AccWidth-1:0] acc;
	logic [AccWidth-1:0] addend;  // c or accumulator
	logic [AccWidth-1:0] sum;

	// operand registers load on every edge, the cfg bits only pick them
	always_ff @(posedge UserCLK) begin
		if (rst) begin
			aReg <= '0;
			bReg <= '0;
			cReg <= '0;
		end else begin
			aReg <= a;
			bReg <= b;
			cReg <= c;
		end
	end

	assign opA = cfg[CfgRegA] ? aReg : a;
	assign opB = cfg[CfgRegB] ? bReg : b;
	assign opC = cfg[CfgRegC] ? cReg : c;

	// widen to the product width first
	// so the low half of the multiply is already the signed result
	assign opAExt = cfg[CfgSigned] ? {{OpWidth{opA[OpWidth-1]}}, opA}
		: {{OpWidth{1'b0}}, opA};
	assign opBExt = cfg[CfgSigned] ? {{OpWidth{opB[OpWidth-1]}}, opB}
		: {{OpWidth{1'b0}}, opB};

	assign product = opAExt * opBExt;  // lower ProdWidth bits kept

	assign productExt = cfg[CfgSigned] ? {{ExtWidth{product[ProdWidth-1]}}, product}
		: {{ExtWidth{1'b0}}, product};

	assign addend = cfg[CfgAccumulate] ? acc : opC;
	assign sum = productExt + addend;  // wraps modulo 2^AccWidth

	// accumulator follows sum unless cleared
	always_ff @(posedge UserCLK) begin
		if (rst || clr) begin
			acc <= '0;
		end else begin
			acc <= sum;
		end
	end

	assign q = cfg[CfgOutAcc] ? acc : sum;

endmodule

/* rtl/sliceCombiner.sv */
module sliceCombiner #(
	parameter int AccWidth = dspTilePkg::AccWidthDef
) (
	input  logic                 UserCLK,
	input  logic                 rst,
	input  logic [AccWidth-1:0]  qA,
	input  logic [AccWidth-1:0]  qB,
	input  dspTilePkg::combCfgT  cfg,
	output logic [AccWidth:0]    dotSum
);

	import dspTilePkg::*;

	logic extSigned;  // fill bit source select
	logic fillA;
	logic fillB;

	logic [AccWidth:0] qAExt;
	logic [AccWidth:0] qBExt;
	logic [AccWidth:0] sumComb;  // unregistered two-tap sum
	logic [AccWidth:0] sumReg;

	assign extSigned = cfg[CombSigned];

	// one extra bit is enough for the sum of two slice results
	assign fillA = extSigned & qA[AccWidth-1];
	assign fillB = extSigned & qB[AccWidth-1];

	assign qAExt = {fillA, qA};
	assign qBExt = {fillB, qB};

	assign sumComb = qAExt + qBExt;

	// output register, used only when CombRegistered is set
	always_ff @(posedge UserCLK) begin
		if (rst) begin
			sumReg <= '0;
		end else begin
			sumReg <= sumComb;
		end
	end

	// registered path adds one cycle of latency
	assign dotSum = cfg[CombRegistered] ? sumReg : sumComb;

endmodule

/* rtl/dspTile.sv */
module dspTile #(
	parameter int OpWidth = dspTilePkg::OpWidthDef,
	parameter int AccWidth = dspTilePkg::AccWidthDef
) (
	input  logic                 UserCLK,
	input  logic                 rst,
	input  logic                 cfgData,
	input  logic                 cfgShift,
	input  logic                 cfgLatch,
	input  logic                 clr0,
	input  logic                 clr1,
	input  dspTilePkg::operandT  a0,
	input  dspTilePkg::operandT  b0,
	input  dspTilePkg::operandT  a1,
	input  dspTilePkg::operandT  b1,
	input  dspTilePkg::accT      c0,
	input  dspTilePkg::accT      c1,
	output dspTilePkg::accT      qA,
	output dspTilePkg::accT      qB,
	output dspTilePkg::dotSumT   dotSum
);

	import dspTilePkg::*;

	sliceCfgT sliceCfg0;  // active frame fields
	sliceCfgT sliceCfg1;
	combCfgT combCfg;

	configChain chain (
		.UserCLK   (UserCLK),
		.rst       (rst),
		.cfgData   (cfgData),
		.cfgShift  (cfgShift),
		.cfgLatch  (cfgLatch),
		.sliceCfg0 (sliceCfg0),
		.sliceCfg1 (sliceCfg1),
		.combCfg   (combCfg)
	);

	// two independent slices, each with its own clear
	mulAdd #(
		.OpWidth  (OpWidth),
		.AccWidth (AccWidth)
	) slice0 (
		.UserCLK (UserCLK),
		.rst     (rst),
		.clr     (clr0),
		.a       (a0),
		.b       (b0),
		.c       (c0),
		.cfg     (sliceCfg0),
		.q       (qA)
	);

	mulAdd #(
		.OpWidth  (OpWidth),
		.AccWidth (AccWidth)
	) slice1 (
		.UserCLK (UserCLK),
		.rst     (rst),
		.clr     (clr1),
		.a       (a1),
		.b       (b1),
		.c       (c1),
		.cfg     (sliceCfg1),
		.q       (qB)
	);

	sliceCombiner #(
		.AccWidth (AccWidth)
	) combiner (
		.UserCLK (UserCLK),
		.rst     (rst),
		.qA      (qA),
		.qB      (qB),
		.cfg     (combCfg),
		.dotSum  (dotSum)
	);

endmodule

/* testbench/dspTile_props.sv */
module dspTileProps (
	input logic                  UserCLK,
	input logic                  rst,
	input logic                  cfgData,
	input logic                  cfgShift,
	input logic                  cfgLatch,
	input dspTilePkg::sliceCfgT  sliceCfg0,
	input dspTilePkg::sliceCfgT  sliceCfg1,
	input dspTilePkg::combCfgT   combCfg,
	input dspTilePkg::accT       qA,
	input dspTilePkg::accT       qB,
	input dspTilePkg::dotSumT    dotSum
);

	timeunit 1ns;
	timeprecision 100ps;

	import dspTilePkg::*;

	int assertFails = 0;

	logic [FrameBits-1:0] frameShadow;  // mirrors the serial load
	logic [FrameBits-1:0] activeFrame;
	dotSumT sumExpected;

	always_ff @(posedge UserCLK) begin
		if (rst) begin
			frameShadow <= '0;
		end else if (cfgShift) begin
			frameShadow <= {frameShadow[FrameBits-2:0], cfgData};
		end
	end

	assign activeFrame = {combCfg, sliceCfg1, sliceCfg0};

	// integer sum of both results cut to the dotSum width
	assign sumExpected = combCfg[CombSigned]
		? dotSumT'(int'($signed(qA)) + int'($signed(qB)))
		: dotSumT'(int'(qA) + int'(qB));

	resetClearsCfg: assert property (@(posedge UserCLK) rst |=> (activeFrame == '0))
		else begin
			assertFails++;
			$error("configuration not zero after reset");
		end

	latchLoadsFrame: assert property (@(posedge UserCLK) disable iff (rst)
		cfgLatch |=> (activeFrame == $past(frameShadow)))
		else begin
			assertFails++;
			$error("active frame differs from the frame shifted in");
		end

	// bypass path must be the plain extended sum
	directSum: assert property (@(posedge UserCLK) disable iff (rst)
		!combCfg[CombRegistered] |-> (dotSum == sumExpected))
		else begin
			assertFails++;
			$error("dotSum differs from qA plus qB");
		end

endmodule

bind dspTile dspTileProps props (
	.UserCLK   (UserCLK),
	.rst       (rst),
	.cfgData   (cfgData),
	.cfgShift  (cfgShift),
	.cfgLatch  (cfgLatch),
	.sliceCfg0 (sliceCfg0),
	.sliceCfg1 (sliceCfg1),
	.combCfg   (combCfg),
	.qA        (qA),
	.qB        (qB),
	.dotSum    (dotSum)
);

/* testbench/dspTileTb.sv */
module dspTileTb;

	timeunit 1ns;
	timeprecision 100ps;

	import dspTilePkg::*;

	localparam string VectorFile = "testbench/dspTileVectors.txt";
	localparam int ResetCycles = 4;
	localparam int CyclesPerFrame = 16;  // 14 shifts, latch edge, release edge
	localparam int MarginCycles = 20;

	// one line of the vector file, config or data
	typedef struct packed {
		logic isCfg;
		logic [FrameBits-1:0] frame;
		logic latch;
		operandT a0;
		operandT b0;
		accT c0;
		logic clr0;
		operandT a1;
		operandT b1;
		accT c1;
		logic clr1;
		accT expQA;
		accT expQB;
		dotSumT expDot;
		int lineNo;
	} vecLineT;

	logic UserCLK;
	logic rst;
	logic cfgData;
	logic cfgShift;
	logic cfgLatch;
	logic clr0;
	logic clr1;
	operandT a0;
	operandT b0;
	operandT a1;
	operandT b1;
	accT c0;
	accT c1;
	accT qA;
	accT qB;
	dotSumT dotSum;

	vecLineT vectors[$];
	int configLines = 0;
	int dataLines = 0;
	int mismatchCount = 0;
	int otherErrors = 0;
	int cycleCount = 0;
	int cycleLimit = MarginCycles;

	dspTile #(
		.OpWidth  (OpWidthDef),
		.AccWidth (AccWidthDef)
	) dut (
		.UserCLK  (UserCLK),
		.rst      (rst),
		.cfgData  (cfgData),
		.cfgShift (cfgShift),
		.cfgLatch (cfgLatch),
		.clr0     (clr0),
		.clr1     (clr1),
		.a0       (a0),
		.b0       (b0),
		.a1       (a1),
		.b1       (b1),
		.c0       (c0),
		.c1       (c1),
		.qA       (qA),
		.qB       (qB),
		.dotSum   (dotSum)
	);

	always #10 UserCLK = ~UserCLK;  // 20 ns period

	always @(posedge UserCLK) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("timeout, the run went past %0d cycles", cycleLimit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic readVectors();
		int fd;
		int lineNo;
		int fields;
		string line;
		string rest;
		byte ch;
		vecLineT v;
		logic [FrameBits-1:0] frameIn;
		logic latchIn;
		operandT a0In;
		operandT b0In;
		operandT a1In;
		operandT b1In;
		accT c0In;
		accT c1In;
		logic clr0In;
		logic clr1In;
		accT qAIn;
		accT qBIn;
		dotSumT dotIn;
		lineNo = 0;
		fd = $fopen(VectorFile, "r");
		if (fd == 0) begin
			$display("could not open the vector file %s", VectorFile);
			otherErrors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				lineNo++;
				if (line.len() < 2) continue;  // blank line
				ch = line.getc(0);
				rest = line.substr(1, line.len() - 1);
				v = '0;
				v.lineNo = lineNo;
				if (ch == "C") begin
					fields = $sscanf(rest, "%h %h", frameIn, latchIn);
					if (fields != 2) begin
						$display("config line %0d of the vector file is incomplete", lineNo);
						otherErrors++;
					end else begin
						v.isCfg = 1'b1;
						v.frame = frameIn;
						v.latch = latchIn;
						vectors.push_back(v);
						configLines++;
					end
				end else if (ch == "D") begin
					fields = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h %h",
						a0In, b0In, c0In, clr0In, a1In, b1In, c1In, clr1In,
						qAIn, qBIn, dotIn);
					if (fields != 11) begin
						$display("data line %0d of the vector file is incomplete", lineNo);
						otherErrors++;
					end else begin
						v.a0 = a0In;
						v.b0 = b0In;
						v.c0 = c0In;
						v.clr0 = clr0In;
						v.a1 = a1In;
						v.b1 = b1In;
						v.c1 = c1In;
						v.clr1 = clr1In;
						v.expQA = qAIn;
						v.expQB = qBIn;
						v.expDot = dotIn;
						vectors.push_back(v);
						dataLines++;
					end
				end else if (ch != "#") begin
					$display("line %0d of the vector file is neither config nor data", lineNo);
					otherErrors++;
				end
			end
			$fclose(fd);
			if (dataLines == 0) begin
				$display("the vector file holds no data lines");
				otherErrors++;
			end
		end
	endtask

	// operands held at zero and both slices cleared while a frame goes in
	task automatic loadFrame(input logic [FrameBits-1:0] frame, input logic latch);
		for (int i = FrameBits - 1; i >= 0; i--) begin
			@(posedge UserCLK);
			cfgData <= frame[i];  // msb first
			cfgShift <= 1'b1;
			a0 <= '0;
			b0 <= '0;
			c0 <= '0;
			a1 <= '0;
			b1 <= '0;
			c1 <= '0;
			clr0 <= 1'b1;
			clr1 <= 1'b1;
		end
		@(posedge UserCLK);
		cfgShift <= 1'b0;
		cfgData <= 1'b0;
		cfgLatch <= latch;  // low leaves the old frame active
		@(posedge UserCLK);
		cfgLatch <= 1'b0;
	endtask

	task automatic checkOutputs(input vecLineT v);
		if (qA !== v.expQA) begin
			mismatchCount++;
			$display("MISMATCH at %0d ns: vector line %0d, qA expected %05h, observed %05h",
				$time, v.lineNo, v.expQA, qA);
		end
		if (qB !== v.expQB) begin
			mismatchCount++;
			$display("MISMATCH at %0d ns: vector line %0d, qB expected %05h, observed %05h",
				$time, v.lineNo, v.expQB, qB);
		end
		if (dotSum !== v.expDot) begin
			mismatchCount++;
			$display("MISMATCH at %0d ns: vector line %0d, dotSum expected %06h, observed %06h",
				$time, v.lineNo, v.expDot, dotSum);
		end
	endtask

	task automatic applyLine(input vecLineT v);
		@(posedge UserCLK);
		a0 <= v.a0;
		b0 <= v.b0;
		c0 <= v.c0;
		clr0 <= v.clr0;
		a1 <= v.a1;
		b1 <= v.b1;
		c1 <= v.c1;
		clr1 <= v.clr1;
		@(negedge UserCLK);  // outputs settled mid cycle
		checkOutputs(v);
	endtask

	initial begin
		UserCLK = 1'b0;
		rst = 1'b1;
		cfgData = 1'b0;
		cfgShift = 1'b0;
		cfgLatch = 1'b0;
		clr0 = 1'b0;
		clr1 = 1'b0;
		a0 = '0;
		b0 = '0;
		a1 = '0;
		b1 = '0;
		c0 = '0;
		c1 = '0;
		readVectors();
		cycleLimit = ResetCycles + CyclesPerFrame * configLines + dataLines + MarginCycles;
		if (otherErrors == 0) begin
			repeat (ResetCycles) @(posedge UserCLK);
			rst <= 1'b0;
			foreach (vectors[i]) begin
				if (vectors[i].isCfg) begin
					loadFrame(vectors[i].frame, vectors[i].latch);
				end else begin
					applyLine(vectors[i]);
				end
			end
		end
		$display("errors: %0d mismatches, %0d assertion failures, %0d other",
			mismatchCount, dut.props.assertFails, otherErrors);
		if (mismatchCount == 0 && otherErrors == 0 && dut.props.assertFails == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* testbench/dspTileVectors.txt */
# config line: C frame latch (frame is 14 bits hex, sent msb first; latch 1 makes it active)
# data line: D a0 b0 c0 clr0 a1 b1 c1 clr1 qA qB dotSum (hex, last three are expected)
#
# zero frame, direct operands, add c, unsigned slices and combiner
C 0000 1
D 03 04 00005 0 10 10 00000 0 00011 00100 000111
D FF FF 00000 0 FF 02 00100 0 0FE01 002FE 0100FF
D FF FF FFFFF 0 00 00 FFFFF 0 0FE00 FFFFF 10FDFF
D 80 02 12345 0 07 09 00001 0 12445 00040 012485
#
# signed multiply in both slices, signed combiner
C 1410 1
D FE 03 00000 0 05 04 00000 0 FFFFA 00014 00000E
D 80 80 00000 0 80 7F 00000 0 04000 FC080 000080
D FF FF FFFF0 0 F0 10 00010 0 FFFF1 FFF10 1FFF01
D 7F 7F 00000 0 81 7F 00000 0 03F01 FC0FF 000000
D 80 7F 80000 0 80 80 80000 0 7C080 84000 000080
#
# accumulate with accumulator output, c is ignored
# q shows the total of the products from earlier lines, clr restarts it
C 0A28 1
D 02 03 00100 0 10 01 00200 0 00000 00000 000000
D 04 05 00100 0 10 01 00200 0 00006 00010 000016
D 0A 0A 00000 1 10 01 00000 0 0001A 00020 00003A
D 03 03 00000 0 00 00 00000 0 00000 00030 000030
D 00 00 00000 0 FF FF 00000 0 00009 00030 000039
D 00 00 00000 0 00 00 00000 1 00009 0FE31 00FE3A
D 00 00 00000 0 00 00 00000 0 00009 00000 000009
#
# slice 0 with registered a, b and c, slice 1 direct
C 0007 1
D 05 06 00010 0 02 03 00001 0 00000 00007 000007
D 07 08 00020 0 04 04 00000 0 0002E 00010 00003E
D 00 00 00000 0 0C 0C 00005 0 00058 00095 0000ED
D FF 01 00001 0 00 00 00000 0 00000 00000 000000
D 00 00 00000 0 00 00 00000 0 00100 00000 000100
#
# registered combiner, dotSum lags one line
C 2000 1
D 02 02 00000 0 03 03 00000 0 00004 00009 000000
D 10 10 00000 0 01 01 00000 0 00100 00001 00000D
D 00 00 00007 0 00 00 00008 0 00007 00008 000101
#
# accumulate frame shifted in without latch, registered combiner stays active
C 0A28 0
D 05 05 00001 0 06 06 00002 0 0001A 00026 000000
D 01 01 00000 0 01 01 00000 0 00001 00001 000040
D 00 00 00000 0 00 00 00000 0 00000 00000 000002
#
# back to the zero frame, c1 wraps
C 0000 1
D 0B 0B 00000 0 01 01 FFFFF 0 00079 00000 000079

/* dspTile.f */
rtl/dspTilePkg.sv
rtl/configChain.sv
rtl/mulAdd.sv
rtl/sliceCombiner.sv
rtl/dspTile.sv
testbench/dspTile_props.sv
testbench/dspTileTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the dspTile testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/100ps \
	--top-module dspTileTb -f dspTile.f -Mdir obj_dir -o dspTileSim

# the log decides the result, so a failing run must not stop the script here
./obj_dir/dspTileSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
